// ==== Makefile ====
# Verilator build and run for the branch compare unit

VERILATOR ?= verilator
TOP       ?= compare_unit_tb
FILELIST  ?= compare_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
LINTFLAGS ?=
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -j 0 -Mdir $(BUILD_DIR) \
		--top-module $(TOP) -f $(FILELIST) $(VFLAGS)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST) $(LINTFLAGS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compare_unit.f ====
logic/cmp_pkg.sv
logic/cmp_lane_if.sv
logic/magnitude_comparator.sv
logic/branch_compare_lane.sv
logic/compare_dispatcher.sv
logic/compare_collector.sv
logic/compare_unit.sv
verification/compare_unit_tb.sv

// ==== logic/branch_compare_lane.sv ====
`timescale 1ns/1ps

// single stage compare lane
// registers one request, compares the operands and resolves the branch condition
module branch_compare_lane (
	input  logic   clk,
	input  logic   arst_n,
	cmp_lane_if.dst issue,
	cmp_lane_if.src result
);

	// registered request
	logic              req_vld_q;
	cmp_pkg::cmp_req_t req_q;

	// compare outputs
	logic                is_signed;
	cmp_pkg::cmp_flags_t flags;
	logic                taken;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req_vld_q <= 1'b0;
		end else begin
			req_vld_q <= issue.valid;
		end
	end

	// payload only loads on a valid issue
	always_ff @(posedge clk) begin
		if (issue.valid) begin
			req_q <= issue.payload;
		end
	end

	// bit 1 of funct3 selects unsigned
	assign is_signed = ~req_q.cond[1];

	magnitude_comparator u_cmp (
		.a        (req_q.a),
		.b        (req_q.b),
		.is_signed(is_signed),
		.flags    (flags)
	);

	// branch decision
	always_comb begin
		case (req_q.cond)
			cmp_pkg::BEQ:  taken = flags.equal;
			cmp_pkg::BNE:  taken = ~flags.equal;
			cmp_pkg::BLT,
			cmp_pkg::BLTU: taken = flags.less;
			cmp_pkg::BGE,
			cmp_pkg::BGEU: taken = ~flags.less;
			default:       taken = 1'b0;
		endcase
	end

	assign result.valid         = req_vld_q;
	assign result.payload.flags = flags;
	assign result.payload.taken = taken;
	assign result.payload.tag   = req_q.tag;

	// the stage never stalls, so a freed collector slot also frees this lane
	assign issue.credit = result.credit;

endmodule

// ==== logic/cmp_lane_if.sv ====
`timescale 1ns/1ps

// valid and payload channel with a credit pulse flowing back
// a source raises valid only while it holds a credit
// every valid cycle spends one credit, every credit pulse returns one
interface cmp_lane_if #(
	parameter type payload_t = logic
) ();

	// forward direction
	logic     valid;
	payload_t payload;

	// backward direction, one cycle per freed slot
	logic     credit;

	// sending side
	modport src (
		output valid,
		output payload,
		input  credit
	);

	// receiving side
	modport dst (
		input  valid,
		input  payload,
		output credit
	);

endinterface

// ==== logic/cmp_pkg.sv ====
// shared widths, depths and types of the branch compare unit
package cmp_pkg;

	// operand and tag widths
	localparam int DATA_W = 32;
	localparam int TAG_W  = 8;

	// lane count and queue depths, all powers of two so pointers wrap on their own
	localparam int NUM_LANES   = 4;
	localparam int REQ_DEPTH   = 8;
	localparam int LANE_DEPTH  = 2;
	localparam int RSP_CREDITS = 4;

	// derived pointer and counter widths
	localparam int REQ_PTR_W   = $clog2(REQ_DEPTH);
	localparam int REQ_CNT_W   = $clog2(REQ_DEPTH + 1);
	localparam int LANE_PTR_W  = $clog2(NUM_LANES);
	localparam int LANE_QPTR_W = $clog2(LANE_DEPTH);
	// lane credits and lane queue fill both range over 0..LANE_DEPTH
	localparam int LANE_CNT_W  = $clog2(LANE_DEPTH + 1);
	localparam int RSP_CRD_W   = $clog2(RSP_CREDITS + 1);

	// branch funct3 codes, bit 1 clear means signed compare
	typedef enum logic [2:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} branch_cond_e;

	// exactly one flag is set
	typedef struct packed {
		logic greater;
		logic equal;
		logic less;
	} cmp_flags_t;

	typedef struct packed {
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		branch_cond_e      cond;
		logic [TAG_W-1:0]  tag;
	} cmp_req_t;

	typedef struct packed {
		cmp_flags_t       flags;
		logic             taken;
		logic [TAG_W-1:0] tag;
	} cmp_rsp_t;

endpackage

// ==== logic/compare_collector.sv ====
`timescale 1ns/1ps

// per-lane response queues, drained in the same lane order the dispatcher used
module compare_collector (
	input  logic              clk,
	input  logic              arst_n,
	cmp_lane_if.dst           result [cmp_pkg::NUM_LANES],
	output logic              rsp_valid,
	output cmp_pkg::cmp_rsp_t rsp,
	input  logic              rsp_credit
);

	// queue storage, one small queue per lane
	cmp_pkg::cmp_rsp_t               lane_mem [cmp_pkg::NUM_LANES][cmp_pkg::LANE_DEPTH];
	logic [cmp_pkg::LANE_QPTR_W-1:0] lane_wr_ptr [cmp_pkg::NUM_LANES];
	logic [cmp_pkg::LANE_QPTR_W-1:0] lane_rd_ptr [cmp_pkg::NUM_LANES];
	logic [cmp_pkg::LANE_CNT_W-1:0]  lane_cnt [cmp_pkg::NUM_LANES];

	// lane side, gathered out of the interface array
	logic [cmp_pkg::NUM_LANES-1:0]   lane_push;
	logic [cmp_pkg::NUM_LANES-1:0]   lane_pop;
	cmp_pkg::cmp_rsp_t               lane_data [cmp_pkg::NUM_LANES];

	// read side
	logic [cmp_pkg::LANE_PTR_W-1:0]  rd_lane;
	logic [cmp_pkg::RSP_CRD_W-1:0]   rsp_crd;
	logic                            send;

	// the next response in request order sits at the head of the pointed lane
	assign send      = (lane_cnt[rd_lane] != '0) && (rsp_crd != '0);
	assign rsp_valid = send;
	assign rsp       = lane_mem[rd_lane][lane_rd_ptr[rd_lane]];

	for (genvar i = 0; i < cmp_pkg::NUM_LANES; i++) begin : g_lane
		assign lane_push[i]     = result[i].valid;
		assign lane_data[i]     = result[i].payload;
		assign lane_pop[i]      = send && (rd_lane == cmp_pkg::LANE_PTR_W'(i));
		// slot freed in the cycle the entry leaves
		assign result[i].credit = lane_pop[i];
	end

	// lanes only send with a credit, so a push always has room
	always_ff @(posedge clk) begin
		for (int i = 0; i < cmp_pkg::NUM_LANES; i++) begin
			if (lane_push[i]) begin
				lane_mem[i][lane_wr_ptr[i]] <= lane_data[i];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_lane <= '0;
			rsp_crd <= cmp_pkg::RSP_CRD_W'(cmp_pkg::RSP_CREDITS);
			for (int i = 0; i < cmp_pkg::NUM_LANES; i++) begin
				lane_wr_ptr[i] <= '0;
				lane_rd_ptr[i] <= '0;
				lane_cnt[i]    <= '0;
			end
		end else begin
			if (send) begin
				rd_lane <= rd_lane + cmp_pkg::LANE_PTR_W'(1);
			end
			// downstream credits, one back per freed consumer slot
			case ({rsp_credit, send})
				2'b10:   rsp_crd <= rsp_crd + cmp_pkg::RSP_CRD_W'(1);
				2'b01:   rsp_crd <= rsp_crd - cmp_pkg::RSP_CRD_W'(1);
				default: rsp_crd <= rsp_crd;
			endcase
			for (int i = 0; i < cmp_pkg::NUM_LANES; i++) begin
				if (lane_push[i]) begin
					lane_wr_ptr[i] <= lane_wr_ptr[i] + cmp_pkg::LANE_QPTR_W'(1);
				end
				if (lane_pop[i]) begin
					lane_rd_ptr[i] <= lane_rd_ptr[i] + cmp_pkg::LANE_QPTR_W'(1);
				end
				case ({lane_push[i], lane_pop[i]})
					2'b10:   lane_cnt[i] <= lane_cnt[i] + cmp_pkg::LANE_CNT_W'(1);
					2'b01:   lane_cnt[i] <= lane_cnt[i] - cmp_pkg::LANE_CNT_W'(1);
					default: lane_cnt[i] <= lane_cnt[i];
				endcase
			end
		end
	end

endmodule

// ==== logic/compare_dispatcher.sv ====
`timescale 1ns/1ps

// request queue in front of the lanes
// entries leave in order, one lane after the other, so the collector can
// rebuild request order by walking the lanes the same way
module compare_dispatcher (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              req_valid,
	input  cmp_pkg::cmp_req_t req,
	output logic              req_credit,
	cmp_lane_if.src           issue [cmp_pkg::NUM_LANES]
);

	// queue storage
	cmp_pkg::cmp_req_t              queue_mem [cmp_pkg::REQ_DEPTH];
	logic [cmp_pkg::REQ_PTR_W-1:0]  wr_ptr;
	logic [cmp_pkg::REQ_PTR_W-1:0]  rd_ptr;
	logic [cmp_pkg::REQ_CNT_W-1:0]  count;

	// round-robin lane pointer and credits held per lane
	logic [cmp_pkg::LANE_PTR_W-1:0] lane_ptr;
	logic [cmp_pkg::LANE_CNT_W-1:0] lane_crd [cmp_pkg::NUM_LANES];
	logic [cmp_pkg::NUM_LANES-1:0]  lane_spend;
	logic [cmp_pkg::NUM_LANES-1:0]  lane_ret;
	logic                           issue_fire;

	// head leaves when the pointed lane can take it
	assign issue_fire = (count != '0) && (lane_crd[lane_ptr] != '0);

	// slot freed in the same cycle the entry issues
	assign req_credit = issue_fire;

	for (genvar i = 0; i < cmp_pkg::NUM_LANES; i++) begin : g_lane
		assign lane_spend[i]    = issue_fire && (lane_ptr == cmp_pkg::LANE_PTR_W'(i));
		assign issue[i].valid   = lane_spend[i];
		assign issue[i].payload = queue_mem[rd_ptr];
		assign lane_ret[i]      = issue[i].credit;
	end

	// core only sends while it holds a credit, so a push always has room
	always_ff @(posedge clk) begin
		if (req_valid) begin
			queue_mem[wr_ptr] <= req;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			lane_ptr <= '0;
			for (int i = 0; i < cmp_pkg::NUM_LANES; i++) begin
				lane_crd[i] <= cmp_pkg::LANE_CNT_W'(cmp_pkg::LANE_DEPTH);
			end
		end else begin
			if (req_valid) begin
				wr_ptr <= wr_ptr + cmp_pkg::REQ_PTR_W'(1);
			end
			if (issue_fire) begin
				rd_ptr   <= rd_ptr + cmp_pkg::REQ_PTR_W'(1);
				lane_ptr <= lane_ptr + cmp_pkg::LANE_PTR_W'(1);
			end
			case ({req_valid, issue_fire})
				2'b10:   count <= count + cmp_pkg::REQ_CNT_W'(1);
				2'b01:   count <= count - cmp_pkg::REQ_CNT_W'(1);
				default: count <= count;
			endcase
			// credit back from the lane, credit spent on issue
			for (int i = 0; i < cmp_pkg::NUM_LANES; i++) begin
				case ({lane_ret[i], lane_spend[i]})
					2'b10:   lane_crd[i] <= lane_crd[i] + cmp_pkg::LANE_CNT_W'(1);
					2'b01:   lane_crd[i] <= lane_crd[i] - cmp_pkg::LANE_CNT_W'(1);
					default: lane_crd[i] <= lane_crd[i];
				endcase
			end
		end
	end

endmodule

// ==== logic/compare_unit.sv ====
`timescale 1ns/1ps

// branch compare unit
// dispatcher -> NUM_LANES compare lanes -> collector, credit flow control throughout
module compare_unit (
	input  logic                        clk,
	input  logic                        arst_n,

	// request side, core starts with REQ_DEPTH credits
	input  logic                        req_valid,
	input  logic [cmp_pkg::DATA_W-1:0]  req_a,
	input  logic [cmp_pkg::DATA_W-1:0]  req_b,
	input  cmp_pkg::branch_cond_e       req_cond,
	input  logic [cmp_pkg::TAG_W-1:0]   req_tag,
	output logic                        req_credit,

	// response side, consumer pulses rsp_credit per freed slot
	output logic                        rsp_valid,
	output cmp_pkg::cmp_flags_t         rsp_flags,
	output logic                        rsp_taken,
	output logic [cmp_pkg::TAG_W-1:0]   rsp_tag,
	input  logic                        rsp_credit
);

	cmp_pkg::cmp_req_t req;
	cmp_pkg::cmp_rsp_t rsp;

	// dispatcher to lanes, lanes to collector
	cmp_lane_if #(.payload_t(cmp_pkg::cmp_req_t)) issue  [cmp_pkg::NUM_LANES] ();
	cmp_lane_if #(.payload_t(cmp_pkg::cmp_rsp_t)) result [cmp_pkg::NUM_LANES] ();

	// pack request ports
	assign req.a    = req_a;
	assign req.b    = req_b;
	assign req.cond = req_cond;
	assign req.tag  = req_tag;

	compare_dispatcher u_dispatcher (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req       (req),
		.req_credit(req_credit),
		.issue     (issue)
	);

	for (genvar i = 0; i < cmp_pkg::NUM_LANES; i++) begin : g_lane
		branch_compare_lane u_lane (
			.clk   (clk),
			.arst_n(arst_n),
			.issue (issue[i]),
			.result(result[i])
		);
	end

	compare_collector u_collector (
		.clk       (clk),
		.arst_n    (arst_n),
		.result    (result),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.rsp_credit(rsp_credit)
	);

	// unpack response
	assign rsp_flags = rsp.flags;
	assign rsp_taken = rsp.taken;
	assign rsp_tag   = rsp.tag;

endmodule

// ==== logic/magnitude_comparator.sv ====
`timescale 1ns/1ps

// combinational 32-bit compare, signed or unsigned
// negative operands go to magnitude first, then a group tree compares magnitudes
// and the two sign bits fix up the answer
module magnitude_comparator (
	input  logic [cmp_pkg::DATA_W-1:0] a,
	input  logic [cmp_pkg::DATA_W-1:0] b,
	input  logic                       is_signed,
	output cmp_pkg::cmp_flags_t        flags
);

	// magnitudes of a and b
	logic [cmp_pkg::DATA_W-1:0] mag_a;
	logic [cmp_pkg::DATA_W-1:0] mag_b;

	// first stage, one greater and one smaller bit per 4-bit group
	logic [7:0] g1;
	logic [7:0] s1;

	// second stage, one pair per four groups
	logic [1:0] g2;
	logic [1:0] s2;

	// magnitude result and sign corrected result
	logic g;
	logic s;
	logic gt;
	logic lt;

	// sign bits, used by the fix up table
	logic sign_a;
	logic sign_b;

	// greater/smaller of two 4-bit vectors
	// bit 1 of the return is greater, bit 0 is smaller
	function automatic logic [1:0] group_cmp(input logic [3:0] x, input logic [3:0] y);
		logic [1:0] gs;
		gs = 2'b00;
		// walk upward so the highest differing bit has the last word
		for (int k = 0; k < 4; k++) begin
			if (x[k] && !y[k]) begin
				gs = 2'b10;
			end else if (!x[k] && y[k]) begin
				gs = 2'b01;
			end
		end
		return gs;
	endfunction

	assign sign_a = a[cmp_pkg::DATA_W-1];
	assign sign_b = b[cmp_pkg::DATA_W-1];

	// two's complement of negative values in signed mode
	// 80000000 stays 80000000, which is still the right magnitude when read unsigned
	assign mag_a = (is_signed && sign_a) ? (~a + cmp_pkg::DATA_W'(1)) : a;
	assign mag_b = (is_signed && sign_b) ? (~b + cmp_pkg::DATA_W'(1)) : b;

	always_comb begin
		// eight nibble compares
		for (int i = 0; i < 8; i++) begin
			{g1[i], s1[i]} = group_cmp(mag_a[4*i +: 4], mag_b[4*i +: 4]);
		end
		// g1 and s1 never share a set bit, so comparing them as numbers
		// picks the highest group that differs
		for (int j = 0; j < 2; j++) begin
			{g2[j], s2[j]} = group_cmp(g1[4*j +: 4], s1[4*j +: 4]);
		end
		// last stage only has two groups, upper bits padded
		{g, s} = group_cmp({2'b00, g2}, {2'b00, s2});
	end

	// sign fix up
	always_comb begin
		case ({is_signed, sign_a, sign_b})
			3'b101: begin
				// a positive, b negative
				gt = 1'b1;
				lt = 1'b0;
			end
			3'b110: begin
				// a negative, b positive
				gt = 1'b0;
				lt = 1'b1;
			end
			3'b111: begin
				// both negative, the larger magnitude is the smaller value
				// equal magnitudes stay equal
				gt = s;
				lt = g;
			end
			default: begin
				// unsigned, or both positive
				gt = g;
				lt = s;
			end
		endcase
	end

	assign flags.greater = gt;
	assign flags.less    = lt;
	assign flags.equal   = ~gt & ~lt;

endmodule

// ==== verification/compare_unit_tb.sv ====
`timescale 1ns/1ps

// testbench for the branch compare unit
// a credit-limited request driver, a response monitor with a credit returning
// consumer, and a reference model built on native signed and unsigned compares
module compare_unit_tb;

	logic                       clk;
	logic                       arst_n;
	logic                       req_valid;
	logic [cmp_pkg::DATA_W-1:0] req_a;
	logic [cmp_pkg::DATA_W-1:0] req_b;
	cmp_pkg::branch_cond_e      req_cond;
	logic [cmp_pkg::TAG_W-1:0]  req_tag;
	logic                       req_credit;
	logic                       rsp_valid;
	cmp_pkg::cmp_flags_t        rsp_flags;
	logic                       rsp_taken;
	logic [cmp_pkg::TAG_W-1:0]  rsp_tag;
	logic                       rsp_credit;

	// bookkeeping
	int    credits;
	int    sent_total;
	int    rsp_count;
	int    owed;
	int    errors;
	int    checks;
	int    base_errors;
	int    base_checks;
	int    cycle_cnt;
	bit    hold_rsp;
	string cur_test;
	logic [31:0] lcg_state;
	cmp_pkg::cmp_rsp_t exp_q [$];

	// pairs that split signed from unsigned order
	logic [31:0] edge_a [8] = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff,
		32'hfffffff0, 32'hffffff00, 32'h12345678, 32'h80000000};
	logic [31:0] edge_b [8] = '{32'hffffffff, 32'h0, 32'h7fffffff, 32'h80000000,
		32'hffffff00, 32'hfffffff0, 32'h12345678, 32'h80000000};

	compare_unit dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req_a     (req_a),
		.req_b     (req_b),
		.req_cond  (req_cond),
		.req_tag   (req_tag),
		.req_credit(req_credit),
		.rsp_valid (rsp_valid),
		.rsp_flags (rsp_flags),
		.rsp_taken (rsp_taken),
		.rsp_tag   (rsp_tag),
		.rsp_credit(rsp_credit)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// run limit grows with the traffic sent so far
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > 20 * sent_total + 200) begin
			$display("timeout after %0d cycles, responses stopped coming", cycle_cnt);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic cmp_pkg::branch_cond_e cond_from_index(input int idx);
		case (idx)
			0:       return cmp_pkg::BEQ;
			1:       return cmp_pkg::BNE;
			2:       return cmp_pkg::BLT;
			3:       return cmp_pkg::BGE;
			4:       return cmp_pkg::BLTU;
			default: return cmp_pkg::BGEU;
		endcase
	endfunction

	// expected response from native compares and the branch rule
	function automatic cmp_pkg::cmp_rsp_t model_rsp(input logic [31:0] a, input logic [31:0] b,
		input cmp_pkg::branch_cond_e cond, input logic [cmp_pkg::TAG_W-1:0] tag);
		cmp_pkg::cmp_rsp_t r;
		bit                sgn;
		sgn = (cond == cmp_pkg::BLT) || (cond == cmp_pkg::BGE) ||
			(cond == cmp_pkg::BEQ) || (cond == cmp_pkg::BNE);
		if (sgn) begin
			r.flags.greater = $signed(a) > $signed(b);
			r.flags.less    = $signed(a) < $signed(b);
		end else begin
			r.flags.greater = a > b;
			r.flags.less    = a < b;
		end
		r.flags.equal = (a == b);
		case (cond)
			cmp_pkg::BEQ:  r.taken = r.flags.equal;
			cmp_pkg::BNE:  r.taken = !r.flags.equal;
			cmp_pkg::BLT,
			cmp_pkg::BLTU: r.taken = r.flags.less;
			default:       r.taken = !r.flags.less;
		endcase
		r.tag = tag;
		return r;
	endfunction

	task automatic check_flags(input cmp_pkg::cmp_flags_t exp, input cmp_pkg::cmp_flags_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: flags expected %b actual %b", cur_test, exp, act);
		end
	endtask

	task automatic check_taken(input bit exp, input bit act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: taken expected %b actual %b", cur_test, exp, act);
		end
	endtask

	task automatic check_tag(input logic [cmp_pkg::TAG_W-1:0] exp,
		input logic [cmp_pkg::TAG_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: tag expected %0d actual %0d", cur_test, exp, act);
		end
	endtask

	task automatic check_count(input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("[ERROR] %s: count expected %0d actual %0d", cur_test, exp, act);
		end
	endtask

	// monitor at the edge, consumer credit 1 ns later
	always @(posedge clk) begin : rsp_monitor
		cmp_pkg::cmp_rsp_t exp;
		if (arst_n) begin
			if (req_credit) begin
				credits++;
			end
			if (rsp_valid) begin
				rsp_count++;
				owed++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("%s: a response came out with no request outstanding", cur_test);
				end else begin
					exp = exp_q.pop_front();
					check_flags(exp.flags, rsp_flags);
					check_taken(exp.taken, rsp_taken);
					check_tag(exp.tag, rsp_tag);
				end
			end
		end
		#1;
		// one credit back per consumed response unless held
		if (!hold_rsp && owed > 0) begin
			rsp_credit = 1'b1;
			owed--;
		end else begin
			rsp_credit = 1'b0;
		end
	end

	// called 1 ns after an edge, returns 1 ns after a later edge
	task automatic send_req(input logic [31:0] a, input logic [31:0] b,
		input cmp_pkg::branch_cond_e cond);
		while (credits == 0) begin
			@(posedge clk);
			#1;
		end
		req_valid = 1'b1;
		req_a     = a;
		req_b     = b;
		req_cond  = cond;
		req_tag   = sent_total[cmp_pkg::TAG_W-1:0];
		exp_q.push_back(model_rsp(a, b, cond, sent_total[cmp_pkg::TAG_W-1:0]));
		credits--;
		sent_total++;
		@(posedge clk);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || owed != 0) begin
			@(posedge clk);
			#1;
		end
		repeat (3) @(posedge clk);
		#1;
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		base_errors = errors;
		base_checks = checks;
	endtask

	task automatic finish_test();
		$display("%s: %0d checks, %0d errors", cur_test, checks - base_checks,
			errors - base_errors);
	endtask

	task automatic test_reset_state();
		start_test("test_reset_state");
		repeat (10) begin
			@(posedge clk);
			checks++;
			if (rsp_valid !== 1'b0 || req_credit !== 1'b0) begin
				errors++;
				$display("%s: rsp_valid or req_credit went high with no traffic", cur_test);
			end
		end
		#1;
		finish_test();
	endtask

	task automatic test_signed_unsigned_edges();
		start_test("test_signed_unsigned_edges");
		for (int i = 0; i < 8; i++) begin
			for (int c = 0; c < 6; c++) begin
				send_req(edge_a[i], edge_b[i], cond_from_index(c));
			end
		end
		wait_drain();
		finish_test();
	endtask

	task automatic test_random_stream();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		start_test("test_random_stream");
		for (int n = 0; n < 200; n++) begin
			a = lcg_next();
			b = lcg_next();
			r = lcg_next();
			// roughly one in sixteen pairs compares equal
			if (r[3:0] == 4'h0) begin
				b = a;
			end
			send_req(a, b, cond_from_index(int'(r[15:8] % 6)));
		end
		wait_drain();
		finish_test();
	endtask

	task automatic test_backpressure();
		int idle;
		int base_sent;
		int base_rsp;
		int accepted;
		int limit;
		start_test("test_backpressure");
		limit     = cmp_pkg::REQ_DEPTH + cmp_pkg::NUM_LANES * cmp_pkg::LANE_DEPTH +
			cmp_pkg::RSP_CREDITS;
		hold_rsp  = 1'b1;
		base_sent = sent_total;
		base_rsp  = rsp_count;
		idle      = 0;
		// keep sending until req_credit has been quiet for a while
		// or the unit has taken more than it can hold
		while (idle < 30 && (sent_total - base_sent) <= limit) begin
			if (credits > 0) begin
				idle = 0;
				send_req(lcg_next(), lcg_next(), cond_from_index(int'(lcg_next() % 6)));
			end else begin
				idle++;
				@(posedge clk);
				#1;
			end
		end
		accepted = sent_total - base_sent;
		checks++;
		if (accepted > limit) begin
			errors++;
			$display("%s: %0d requests accepted while the unit can only hold %0d",
				cur_test, accepted, limit);
		end
		// only the initial downstream credits may have drained
		check_count(cmp_pkg::RSP_CREDITS, rsp_count - base_rsp);
		hold_rsp = 1'b0;
		wait_drain();
		finish_test();
	endtask

	task automatic test_credit_accounting();
		start_test("test_credit_accounting");
		check_count(cmp_pkg::REQ_DEPTH, credits);
		finish_test();
	endtask

	initial begin
		clk        = 1'b0;
		arst_n     = 1'b0;
		req_valid  = 1'b0;
		req_a      = '0;
		req_b      = '0;
		req_cond   = cmp_pkg::BEQ;
		req_tag    = '0;
		rsp_credit = 1'b0;
		hold_rsp   = 1'b0;
		credits    = cmp_pkg::REQ_DEPTH;
		sent_total = 0;
		rsp_count  = 0;
		owed       = 0;
		errors     = 0;
		checks     = 0;
		cycle_cnt  = 0;
		cur_test   = "reset";
		lcg_state  = 32'he40d2255;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;

		test_reset_state();
		test_signed_unsigned_edges();
		test_credit_accounting();
		test_random_stream();
		test_credit_accounting();
		test_backpressure();
		test_credit_accounting();

		$display("requests %0d, checks %0d, errors %0d", sent_total, checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
